//--- cpu_core.f
cpu_pkg.sv
instr_decoder.sv
reg_write_steer.sv
reg_pair.sv
reg_operand_unit.sv
bus_sequencer.sv
cpu_core.sv
cpu_core_checker.sv
tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f cpu_core.f --top-module tb_cpu_core -o sim_cpu_core
./obj_dir/sim_cpu_core +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

//--- tb_cpu_core.sv
module tb_cpu_core;

  timeunit 1ns;
  timeprecision 100ps;

  // code holds len opcode bytes, the first one in the most significant position
  typedef struct packed {
    logic [3:0]     len;
    logic [63:0]    code;
    logic           exp_wr;
    cpu_pkg::addr_t exp_addr;
    cpu_pkg::byte_t exp_data;
  } row_t;

  logic           clk = 1'b0;
  logic           rst;
  cpu_pkg::byte_t mem_rd_data;
  cpu_pkg::addr_t mem_rd_addr;
  logic           mem_wr_en;
  cpu_pkg::addr_t mem_wr_addr;
  cpu_pkg::byte_t mem_wr_data;

  cpu_pkg::byte_t mem [65536];
  cpu_pkg::byte_t data_region [256];
  row_t           rows [$];
  string          names [$];
  int             write_count = 0;
  int             mismatch_count = 0;
  int             timeout_count = 0;
  int             assert_count = 0;

  always #2 clk = ~clk;

  cpu_core cpu_core_inst (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_mem_rd_data (mem_rd_data),
    .o_mem_rd_addr (mem_rd_addr),
    .o_mem_wr_en   (mem_wr_en),
    .o_mem_wr_addr (mem_wr_addr),
    .o_mem_wr_data (mem_wr_data)
  );

  bind cpu_core cpu_core_checker cpu_core_checker_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_mem_wr_en   (o_mem_wr_en),
    .i_mem_rd_addr (o_mem_rd_addr)
  );

  assign mem_rd_data = mem[mem_rd_addr];

  always @(posedge clk) begin
    if (mem_wr_en) begin
      mem[mem_wr_addr] <= mem_wr_data;
      write_count      <= write_count + 1;
    end
  end

  // Galois form with taps 32, 30, 26 and 25
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task fill_memory();
    logic [31:0]    lfsr;
    cpu_pkg::byte_t value;
    lfsr = 32'd67482;
    for (int a = 0; a < 65536; a++) begin
      mem[a] <= a[15:8] ^ a[7:0];
    end
    for (int i = 0; i < 256; i++) begin
      value = '0;
      for (int b = 0; b < 8; b++) begin
        value = {value[6:0], lfsr[0]};
        lfsr  = lfsr_step(lfsr);
      end
      data_region[i]  = value;
      mem[16'hC000 + i] <= value;
    end
  endtask

  task automatic add_row(input string name, input int len, input logic [63:0] code,
                         input logic exp_wr, input cpu_pkg::addr_t addr,
                         input cpu_pkg::byte_t data);
    row_t row;
    row.len      = len[3:0];
    row.code     = code;
    row.exp_wr   = exp_wr;
    row.exp_addr = addr;
    row.exp_data = data;
    rows.push_back(row);
    names.push_back(name);
  endtask

  task build_table();
    add_row("nop_fetch",        3, 64'h000000,           0, 16'h0000, 8'h00);
    add_row("ld_r_n_store",     7, 64'h26D0_2E00_065A_70, 1, 16'hD000, 8'h5A);
    add_row("ld_r_r_copy",      6, 64'h163C_5A_2E01_73,   1, 16'hD001, 8'h3C);
    add_row("ld_c_b_store",     4, 64'h48_2E02_71,        1, 16'hD002, 8'h5A);
    add_row("ld_hl_n_store",    2, 64'h36A7,              1, 16'hD002, 8'hA7);
    add_row("ld_h_b_store_n",   3, 64'h60_36E1,           1, 16'h5A02, 8'hE1);
    add_row("ld_d_from_hl",     8, 64'h26C0_2E37_56_26D1_72, 1, 16'hD137, data_region[8'h37]);
    add_row("ld_e_from_hl",     7, 64'h21F2C0_5E_26D2_73, 1, 16'hD2F2, data_region[8'hF2]);
    add_row("inc_dec_hl",       7, 64'h213412_23_2B2B_70, 1, 16'h1233, 8'h5A);
    add_row("hl_wrap_low",      8, 64'h210000_23_2B2B_366B, 1, 16'hFFFF, 8'h6B);
    add_row("hl_wrap_high",     8, 64'h21FFFF_23_2B2B_36C3, 1, 16'hFFFE, 8'hC3);
    add_row("inc_dec_bc",       6, 64'h01FF20_03_0B0B,    0, 16'h0000, 8'h00);
    add_row("copy_bc_store",    4, 64'h60_69_365D,        1, 16'h20FE, 8'h5D);
    add_row("inc_dec_de",       6, 64'h110080_1B_13_1B,   0, 16'h0000, 8'h00);
    add_row("copy_de_store",    3, 64'h62_6B_72,          1, 16'h7FFF, 8'h7F);
    // A forms, then SP forms whose operand bytes are zero and run as NOPs too
    add_row("dropped_a_forms",  6, 64'h3E00_77_47_E000,   0, 16'h0000, 8'h00);
    add_row("dropped_sp_forms", 7, 64'h310000_33_2E00_70, 1, 16'h7F00, 8'h20);
  endtask

  task load_program();
    cpu_pkg::addr_t pc;
    int             len;
    pc = 16'h0100;
    foreach (rows[i]) begin
      len = int'(rows[i].len);
      for (int b = len - 1; b >= 0; b--) begin
        mem[pc] <= rows[i].code[8*b +: 8];
        pc = pc + 16'd1;
      end
    end
    while (pc < 16'h0400) begin
      mem[pc] <= 8'h00;
      pc = pc + 16'd1;
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic wait_fetch(input cpu_pkg::addr_t prev, output cpu_pkg::addr_t addr,
                            output logic ok);
    ok   = 1'b0;
    addr = prev;
    for (int n = 0; n < 400 && !ok; n++) begin
      @(negedge clk);
      addr = mem_rd_addr;
      ok   = addr != prev;
    end
    if (!ok) begin
      $display("timeout: read address stayed at 0x%h for 400 clocks", prev);
      timeout_count++;
    end
  endtask

  task automatic wait_write(input string name, output logic ok);
    ok = 1'b0;
    for (int n = 0; n < 400 && !ok; n++) begin
      @(negedge clk);
      ok = mem_wr_en;
    end
    if (!ok) begin
      $display("timeout: no memory write for %s within 400 clocks", name);
      timeout_count++;
    end
  endtask

  initial begin
    cpu_pkg::addr_t addr;
    logic           ok;
    int             expected_writes;
    rst = 1'b1;
    expected_writes = 0;
    fill_memory();
    build_table();
    load_program();
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    wait_fetch(16'h0000, addr, ok);
    if (ok) begin
      check_value("reset_fetch", 16'h0100, addr);
    end
    for (int k = 1; k <= 3 && ok; k++) begin
      wait_fetch(addr, addr, ok);
      if (ok) begin
        check_value("fetch_sequence", 16'h0100 + 16'(k), addr);
      end
    end
    check_value("nop_no_write", 16'd0, 16'(write_count));

    foreach (rows[i]) begin
      if (rows[i].exp_wr && timeout_count == 0) begin
        expected_writes++;
        wait_write(names[i], ok);
        if (ok) begin
          check_value({names[i], " address"}, rows[i].exp_addr, mem_wr_addr);
          check_value({names[i], " data"}, 16'(rows[i].exp_data), 16'(mem_wr_data));
        end
      end
    end

    // the last store lands on the edge that ends its strobe
    repeat (2) @(negedge clk);
    if (timeout_count == 0) begin
      check_value("write_count", 16'(expected_writes), 16'(write_count));
    end
    assert_count = int'(cpu_core_inst.cpu_core_checker_inst.fail_count);
    $display("mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             mismatch_count, timeout_count, assert_count);
    if (mismatch_count == 0 && timeout_count == 0 && assert_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- cpu_core_checker.sv
module cpu_core_checker (
  input logic           i_clk,
  input logic           i_rst,
  input logic           i_mem_wr_en,
  input cpu_pkg::addr_t i_mem_rd_addr
);

  timeunit 1ns;
  timeprecision 100ps;

  // clocks since the last write strobe, saturating at one machine cycle
  logic [3:0]  gap;
  int unsigned fail_count = 0;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      gap <= 4'(cpu_pkg::T_STATES_PER_M);
    end else if (i_mem_wr_en) begin
      gap <= 4'd1;
    end else if (gap < 4'(cpu_pkg::T_STATES_PER_M)) begin
      gap <= gap + 4'd1;
    end
  end

  wr_single_clock: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mem_wr_en |=> !i_mem_wr_en)
    else begin
      fail_count++;
      $error("write strobe stayed high for a second clock");
    end

  wr_spacing: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mem_wr_en |-> gap >= 4'(cpu_pkg::T_STATES_PER_M))
    else begin
      fail_count++;
      $error("two write strobes closer than one machine cycle");
    end

  rd_addr_known: assert property (@(posedge i_clk) disable iff (i_rst)
    !$isunknown(i_mem_rd_addr))
    else begin
      fail_count++;
      $error("read address has unknown bits");
    end

endmodule

//--- cpu_core.sv
module cpu_core (
  input  logic           i_clk,
  input  logic           i_rst,
  input  cpu_pkg::byte_t i_mem_rd_data,
  output cpu_pkg::addr_t o_mem_rd_addr,
  output logic           o_mem_wr_en,
  output cpu_pkg::addr_t o_mem_wr_addr,
  output cpu_pkg::byte_t o_mem_wr_data
);

  cpu_pkg::byte_t         ir;
  cpu_pkg::decoded_op_t   dec;
  cpu_pkg::reg_idx_t      src_idx;
  cpu_pkg::pair_idx_t     pair_idx;
  cpu_pkg::reg_wr_req_t   wr_req;
  cpu_pkg::pair_we_t      pair_we [cpu_pkg::NUM_PAIRS];
  cpu_pkg::addr_t         pairs [cpu_pkg::NUM_PAIRS];
  cpu_pkg::byte_t         src_byte;
  cpu_pkg::addr_t         hl_addr;
  cpu_pkg::addr_t         pair_adj;

  bus_sequencer u_bus_sequencer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_mem_rd_data (i_mem_rd_data),
    .i_dec         (dec),
    .i_src_byte    (src_byte),
    .i_hl_addr     (hl_addr),
    .i_pair_adj    (pair_adj),
    .o_ir          (ir),
    .o_src_idx     (src_idx),
    .o_pair_idx    (pair_idx),
    .o_wr_req      (wr_req),
    .o_mem_rd_addr (o_mem_rd_addr),
    .o_mem_wr_en   (o_mem_wr_en),
    .o_mem_wr_addr (o_mem_wr_addr),
    .o_mem_wr_data (o_mem_wr_data)
  );

  instr_decoder u_instr_decoder (
    .i_ir  (ir),
    .o_dec (dec)
  );

  reg_write_steer u_reg_write_steer (
    .i_wr_req  (wr_req),
    .o_pair_we (pair_we)
  );

  // BC, DE and HL in pair-code order
  for (genvar i = 0; i < cpu_pkg::NUM_PAIRS; i++) begin : g_pair
    reg_pair u_reg_pair (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_we    (pair_we[i]),
      .i_byte  (wr_req.byte_data),
      .i_word  (wr_req.word_data),
      .o_value (pairs[i])
    );
  end

  reg_operand_unit u_reg_operand_unit (
    .i_pairs    (pairs),
    .i_src_idx  (src_idx),
    .i_pair_idx (pair_idx),
    .i_is_dec   (dec.is_dec),
    .o_src_byte (src_byte),
    .o_hl_addr  (hl_addr),
    .o_pair_adj (pair_adj)
  );

endmodule

//--- bus_sequencer.sv
module bus_sequencer (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  cpu_pkg::byte_t       i_mem_rd_data,
  input  cpu_pkg::decoded_op_t i_dec,
  input  cpu_pkg::byte_t       i_src_byte,
  input  cpu_pkg::addr_t       i_hl_addr,
  input  cpu_pkg::addr_t       i_pair_adj,
  output cpu_pkg::byte_t       o_ir,
  output cpu_pkg::reg_idx_t    o_src_idx,
  output cpu_pkg::pair_idx_t   o_pair_idx,
  output cpu_pkg::reg_wr_req_t o_wr_req,
  output cpu_pkg::addr_t       o_mem_rd_addr,
  output logic                 o_mem_wr_en,
  output cpu_pkg::addr_t       o_mem_wr_addr,
  output cpu_pkg::byte_t       o_mem_wr_data
);

  cpu_pkg::seq_state_t state;
  cpu_pkg::seq_state_t next_state;
  cpu_pkg::t_state_t   t_state;
  cpu_pkg::m_cycle_t   m_cycle;
  cpu_pkg::addr_t      pc;
  cpu_pkg::addr_t      pc_next;
  cpu_pkg::byte_t      ir_q;
  cpu_pkg::byte_t      imm_lo;
  logic                t_last;
  logic                m_last;
  logic                is_store;
  logic                mem_write;

  // during fetch the decoder sees the opcode on the bus, so LD r,r' retires in one cycle
  assign o_ir = (state == cpu_pkg::FETCH) ? i_mem_rd_data : ir_q;

  assign o_src_idx  = i_dec.src_idx;
  assign o_pair_idx = i_dec.pair_idx;

  assign t_last = t_state == cpu_pkg::t_state_t'(cpu_pkg::T_STATES_PER_M - 1);
  assign m_last = m_cycle == cpu_pkg::m_cycle_t'(i_dec.m_cycles - 3'd1);

  assign is_store  = (i_dec.op_class == cpu_pkg::OP_LD_HL_R) ||
                     (i_dec.op_class == cpu_pkg::OP_LD_HL_N);
  assign mem_write = (state == cpu_pkg::MEM_ACCESS) && is_store;

  // every opcode or immediate read moves PC on by one
  assign pc_next = (state == cpu_pkg::FETCH || state == cpu_pkg::OPERAND_LO ||
                    state == cpu_pkg::OPERAND_HI) ? pc + 16'd1 : pc;

  always_comb begin
    next_state = cpu_pkg::FETCH;
    if (!m_last) begin
      case (i_dec.op_class)
        cpu_pkg::OP_LD_R_N: begin
          next_state = cpu_pkg::OPERAND_LO;
        end
        cpu_pkg::OP_LD_R_HL, cpu_pkg::OP_LD_HL_R: begin
          next_state = cpu_pkg::MEM_ACCESS;
        end
        cpu_pkg::OP_LD_HL_N: begin
          next_state = (state == cpu_pkg::FETCH) ? cpu_pkg::OPERAND_LO : cpu_pkg::MEM_ACCESS;
        end
        cpu_pkg::OP_LD_RR_NN: begin
          next_state = (state == cpu_pkg::FETCH) ? cpu_pkg::OPERAND_LO : cpu_pkg::OPERAND_HI;
        end
        cpu_pkg::OP_INC_DEC_RR: begin
          next_state = cpu_pkg::INTERNAL;
        end
        default: begin
          next_state = cpu_pkg::FETCH;
        end
      endcase
    end
  end

  // the register write is only valid in the last T3 and lands on the edge ending it
  always_comb begin
    o_wr_req           = '0;
    o_wr_req.byte_idx  = i_dec.dst_idx;
    o_wr_req.byte_data = i_src_byte;
    o_wr_req.word_idx  = i_dec.pair_idx;
    o_wr_req.word_data = i_pair_adj;
    if (t_last && m_last) begin
      case (i_dec.op_class)
        cpu_pkg::OP_LD_R_R: begin
          o_wr_req.byte_en = 1'b1;
        end
        cpu_pkg::OP_LD_R_N, cpu_pkg::OP_LD_R_HL: begin
          o_wr_req.byte_en   = 1'b1;
          o_wr_req.byte_data = i_mem_rd_data;
        end
        cpu_pkg::OP_LD_RR_NN: begin
          o_wr_req.word_en   = 1'b1;
          o_wr_req.word_data = {i_mem_rd_data, imm_lo};
        end
        cpu_pkg::OP_INC_DEC_RR: begin
          o_wr_req.word_en = 1'b1;
        end
        default: begin
          o_wr_req.byte_en = 1'b0;
        end
      endcase
    end
  end

  // reset parks the machine at the end of an idle cycle, so the first edge starts the fetch
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state         <= cpu_pkg::INTERNAL;
      t_state       <= cpu_pkg::t_state_t'(cpu_pkg::T_STATES_PER_M - 1);
      m_cycle       <= '0;
      pc            <= cpu_pkg::RESET_PC;
      ir_q          <= '0;
      o_mem_rd_addr <= '0;
      o_mem_wr_en   <= 1'b0;
      o_mem_wr_addr <= '0;
      o_mem_wr_data <= '0;
    end else begin
      t_state     <= t_last ? '0 : t_state + 2'd1;
      o_mem_wr_en <= mem_write &&
                     (t_state == cpu_pkg::t_state_t'(cpu_pkg::T_STATES_PER_M - 2));
      if (t_last) begin
        state   <= next_state;
        pc      <= pc_next;
        m_cycle <= m_last ? '0 : m_cycle + 3'd1;
        if (state == cpu_pkg::FETCH) begin
          ir_q <= i_mem_rd_data;
        end
        case (next_state)
          cpu_pkg::FETCH, cpu_pkg::OPERAND_LO, cpu_pkg::OPERAND_HI: begin
            o_mem_rd_addr <= pc_next;
          end
          cpu_pkg::MEM_ACCESS: begin
            if (is_store) begin
              o_mem_wr_addr <= i_hl_addr;
              // LD (HL),n arrives here from its operand cycle with n still on the bus
              o_mem_wr_data <= (i_dec.op_class == cpu_pkg::OP_LD_HL_N) ?
                               i_mem_rd_data : i_src_byte;
            end else begin
              o_mem_rd_addr <= i_hl_addr;
            end
          end
          default: begin
            o_mem_rd_addr <= o_mem_rd_addr;
          end
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (t_last && state == cpu_pkg::OPERAND_LO) begin
      imm_lo <= i_mem_rd_data;
    end
  end

endmodule

//--- reg_operand_unit.sv
module reg_operand_unit (
  input  cpu_pkg::addr_t     i_pairs [cpu_pkg::NUM_PAIRS],
  input  cpu_pkg::reg_idx_t  i_src_idx,
  input  cpu_pkg::pair_idx_t i_pair_idx,
  input  logic               i_is_dec,
  output cpu_pkg::byte_t     o_src_byte,
  output cpu_pkg::addr_t     o_hl_addr,
  output cpu_pkg::addr_t     o_pair_adj
);

  cpu_pkg::addr_t src_word;
  cpu_pkg::addr_t sel_word;

  // codes past the last pair read as zero
  always_comb begin
    src_word = '0;
    sel_word = '0;
    for (int p = 0; p < cpu_pkg::NUM_PAIRS; p++) begin
      if (i_src_idx[2:1] == cpu_pkg::pair_idx_t'(p)) begin
        src_word = i_pairs[p];
      end
      if (i_pair_idx == cpu_pkg::pair_idx_t'(p)) begin
        sel_word = i_pairs[p];
      end
    end
  end

  assign o_src_byte = i_src_idx[0] ? src_word[7:0] : src_word[15:8];
  assign o_hl_addr  = i_pairs[cpu_pkg::PAIR_HL];

  // wraps at 16 bits with no flags
  assign o_pair_adj = i_is_dec ? sel_word - 16'd1 : sel_word + 16'd1;

endmodule

//--- reg_pair.sv
module reg_pair (
  input  logic              i_clk,
  input  logic              i_rst,
  input  cpu_pkg::pair_we_t i_we,
  input  cpu_pkg::byte_t    i_byte,
  input  cpu_pkg::addr_t    i_word,
  output cpu_pkg::addr_t    o_value
);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_value <= '0;
    end else if (i_we.word_en) begin
      o_value <= i_word;
    end else begin
      if (i_we.hi_en) begin
        o_value[15:8] <= i_byte;
      end
      if (i_we.lo_en) begin
        o_value[7:0] <= i_byte;
      end
    end
  end

endmodule

//--- reg_write_steer.sv
module reg_write_steer (
  input  cpu_pkg::reg_wr_req_t i_wr_req,
  output cpu_pkg::pair_we_t    o_pair_we [cpu_pkg::NUM_PAIRS]
);

  cpu_pkg::pair_idx_t byte_pair;
  logic               byte_lo;

  // even codes name the high byte of a pair, odd codes the low byte
  assign byte_pair = i_wr_req.byte_idx[2:1];
  assign byte_lo   = i_wr_req.byte_idx[0];

  always_comb begin
    for (int p = 0; p < cpu_pkg::NUM_PAIRS; p++) begin
      o_pair_we[p].hi_en   = i_wr_req.byte_en && !byte_lo &&
                             (byte_pair == cpu_pkg::pair_idx_t'(p));
      o_pair_we[p].lo_en   = i_wr_req.byte_en && byte_lo &&
                             (byte_pair == cpu_pkg::pair_idx_t'(p));
      o_pair_we[p].word_en = i_wr_req.word_en &&
                             (i_wr_req.word_idx == cpu_pkg::pair_idx_t'(p));
    end
  end

endmodule

//--- instr_decoder.sv
module instr_decoder (
  input  cpu_pkg::byte_t       i_ir,
  output cpu_pkg::decoded_op_t o_dec
);

  cpu_pkg::opcode_t   op;
  cpu_pkg::pair_idx_t pair;
  logic               dst_ok;
  logic               src_ok;
  logic               pair_ok;

  assign op   = i_ir;
  assign pair = op.dst[2:1];

  // code 7 named the accumulator and pair code 3 the stack pointer, both absent here
  assign dst_ok  = ~&op.dst;
  assign src_ok  = ~&op.src;
  assign pair_ok = pair < cpu_pkg::NUM_PAIRS;

  always_comb begin
    o_dec.op_class = cpu_pkg::OP_NOP;
    o_dec.dst_idx  = op.dst;
    o_dec.src_idx  = op.src;
    o_dec.pair_idx = pair;
    o_dec.is_dec   = op.dst[0];
    o_dec.m_cycles = 3'd1;
    case (op.grp)
      cpu_pkg::GRP_LD_R_R: begin
        if (dst_ok && src_ok && i_ir != cpu_pkg::OPC_HALT) begin
          if (op.dst == cpu_pkg::REG_IDX_HL_MEM) begin
            o_dec.op_class = cpu_pkg::OP_LD_HL_R;
            o_dec.m_cycles = 3'd2;
          end else if (op.src == cpu_pkg::REG_IDX_HL_MEM) begin
            o_dec.op_class = cpu_pkg::OP_LD_R_HL;
            o_dec.m_cycles = 3'd2;
          end else begin
            o_dec.op_class = cpu_pkg::OP_LD_R_R;
          end
        end
      end
      cpu_pkg::GRP_MISC: begin
        if (op.src == cpu_pkg::REG_IDX_HL_MEM && dst_ok) begin
          if (op.dst == cpu_pkg::REG_IDX_HL_MEM) begin
            o_dec.op_class = cpu_pkg::OP_LD_HL_N;
            o_dec.m_cycles = 3'd3;
          end else begin
            o_dec.op_class = cpu_pkg::OP_LD_R_N;
            o_dec.m_cycles = 3'd2;
          end
        end else if (pair_ok && op.src == cpu_pkg::LOW_LD_RR_NN && !op.dst[0]) begin
          // bit 3 set here would be ADD HL,rr
          o_dec.op_class = cpu_pkg::OP_LD_RR_NN;
          o_dec.m_cycles = 3'd3;
        end else if (pair_ok && op.src == cpu_pkg::LOW_INC_DEC_RR) begin
          o_dec.op_class = cpu_pkg::OP_INC_DEC_RR;
          o_dec.m_cycles = 3'd2;
        end
      end
      default: begin
        o_dec.op_class = cpu_pkg::OP_NOP;
      end
    endcase
  end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] addr_t;

  // register codes follow the opcode field, code 6 addresses memory through HL
  typedef logic [2:0] reg_idx_t;
  typedef logic [1:0] pair_idx_t;

  typedef logic [2:0] m_cycle_t;
  typedef logic [1:0] t_state_t;

  localparam int        T_STATES_PER_M = 4;
  localparam addr_t     RESET_PC       = 16'h0100;
  localparam int        NUM_PAIRS      = 3;
  localparam reg_idx_t  REG_IDX_HL_MEM = 3'd6;
  localparam pair_idx_t PAIR_HL        = 2'd2;

  // opcode groups in bits 7:6 and the low-field patterns of the 16-bit forms
  localparam logic [1:0] GRP_MISC       = 2'b00;
  localparam logic [1:0] GRP_LD_R_R     = 2'b01;
  localparam reg_idx_t   LOW_LD_RR_NN   = 3'b001;
  localparam reg_idx_t   LOW_INC_DEC_RR = 3'b011;
  localparam byte_t      OPC_HALT       = 8'h76;

  typedef struct packed {
    logic [1:0] grp;
    reg_idx_t   dst;
    reg_idx_t   src;
  } opcode_t;

  typedef enum logic [2:0] {
    OP_NOP,
    OP_LD_R_R,
    OP_LD_R_N,
    OP_LD_R_HL,
    OP_LD_HL_R,
    OP_LD_HL_N,
    OP_LD_RR_NN,
    OP_INC_DEC_RR
  } op_class_t;

  typedef enum logic [2:0] {
    FETCH,
    OPERAND_LO,
    OPERAND_HI,
    MEM_ACCESS,
    INTERNAL
  } seq_state_t;

  typedef struct packed {
    op_class_t op_class;
    reg_idx_t  dst_idx;
    reg_idx_t  src_idx;
    pair_idx_t pair_idx;
    logic      is_dec;
    m_cycle_t  m_cycles;
  } decoded_op_t;

  typedef struct packed {
    logic      byte_en;
    reg_idx_t  byte_idx;
    byte_t     byte_data;
    logic      word_en;
    pair_idx_t word_idx;
    addr_t     word_data;
  } reg_wr_req_t;

  typedef struct packed {
    logic hi_en;
    logic lo_en;
    logic word_en;
  } pair_we_t;

endpackage
